//--- verilog/exec_settings.svh
// datapath and register file widths shared by the execute stage
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// integer data path width
`define XLEN 32

// register file address width
`define REG_ADDR_W 5

`endif

//--- verilog/exec_uop_pkg.sv
// micro-op encodings that select the unit, the operation and the branch rule
package exec_uop_pkg;

    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0, // integer alu
        UNIT_MULDIV = 2'd1  // m-extension unit
    } exec_unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        MD_MUL    = 3'd0, // low half of product
        MD_MULH   = 3'd1, // signed x signed, high half
        MD_MULHSU = 3'd2, // signed x unsigned, high half
        MD_MULHU  = 3'd3, // unsigned x unsigned, high half
        MD_DIV    = 3'd4,
        MD_DIVU   = 3'd5,
        MD_REM    = 3'd6,
        MD_REMU   = 3'd7
    } muldiv_op_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd2,
        BR_GE  = 3'd3,
        BR_LTU = 3'd4,
        BR_GEU = 3'd5
    } branch_cond_e;

    typedef enum logic [1:0] {
        KIND_OTHER  = 2'd0, // never redirects fetch
        KIND_JUMP   = 2'd1,
        KIND_BRANCH = 2'd2
    } instr_kind_e;

    typedef struct packed {
        exec_unit_e   unit;
        alu_op_e      alu_op;
        muldiv_op_e   muldiv_op;
        branch_cond_e branch_cond;
        instr_kind_e  kind;
    } uop_t;

endpackage

//--- verilog/exec_data_pkg.sv
// data bundles exchanged with register read, fetch and writeback
`include "exec_settings.svh"

package exec_data_pkg;

    // relation between the two raw register values, rs1 against rs2
    typedef struct packed {
        logic lt;  // signed less than
        logic ltu; // unsigned less than
        logic eq;
    } cmp_flags_t;

    // pc update request to fetch
    typedef struct packed {
        logic [`XLEN-1:0] target;
        logic             update;
    } redirect_t;

    // registered result handed to the writeback stage
    typedef struct packed {
        logic                   write_en;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`XLEN-1:0]       rd_value;
        logic [`XLEN-1:0]       pc_plus4; // link value for jal and jalr
    } writeback_t;

endpackage

//--- verilog/alu.sv
// integer alu for the rv32i arithmetic, logic, shift and compare operations
`timescale 1ns/10ps

`include "exec_settings.svh"

module alu
    import exec_uop_pkg::*;
(
    input  logic [`XLEN-1:0] operand_a_i,
    input  logic [`XLEN-1:0] operand_b_i,
    input  alu_op_e          op_i,
    output logic [`XLEN-1:0] result_o
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               signed_lt;
    logic               unsigned_lt;

    assign shamt       = operand_b_i[SHAMT_W-1:0]; // upper bits of b are ignored
    assign signed_lt   = $signed(operand_a_i) < $signed(operand_b_i);
    assign unsigned_lt = operand_a_i < operand_b_i;

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = operand_a_i + operand_b_i; // also forms jump and branch targets
            end
            ALU_SUB: begin
                result_o = operand_a_i - operand_b_i;
            end
            ALU_AND: begin
                result_o = operand_a_i & operand_b_i;
            end
            ALU_OR: begin
                result_o = operand_a_i | operand_b_i;
            end
            ALU_XOR: begin
                result_o = operand_a_i ^ operand_b_i;
            end
            ALU_SLL: begin
                result_o = operand_a_i << shamt;
            end
            ALU_SRL: begin
                result_o = operand_a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = $unsigned($signed(operand_a_i) >>> shamt); // sign fill
            end
            ALU_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, signed_lt};
            end
            ALU_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, unsigned_lt};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- verilog/muldiv_unit.sv
// single-cycle m-extension multiply, divide and remainder
`timescale 1ns/10ps

`include "exec_settings.svh"

module muldiv_unit
    import exec_uop_pkg::*;
(
    input  muldiv_op_e       op_i,
    input  logic [`XLEN-1:0] operand_a_i,
    input  logic [`XLEN-1:0] operand_b_i,
    output logic [`XLEN-1:0] result_o
);

    localparam logic [`XLEN-1:0] MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};
    localparam logic [`XLEN-1:0] ONE      = {{(`XLEN-1){1'b0}}, 1'b1};

    logic                      a_signed;
    logic                      b_signed;
    logic signed [`XLEN:0]     a_ext;    // one extra bit carries the sign choice
    logic signed [`XLEN:0]     b_ext;
    logic signed [2*`XLEN+1:0] product;
    logic                      div_zero;
    logic                      div_ovf;
    logic [`XLEN-1:0]          sdivisor;
    logic [`XLEN-1:0]          udivisor;
    logic [`XLEN-1:0]          quot_s;
    logic [`XLEN-1:0]          rem_s;
    logic [`XLEN-1:0]          quot_u;
    logic [`XLEN-1:0]          rem_u;

    // operand signedness per multiply variant
    always_comb begin
        a_signed = (op_i == MD_MULH) || (op_i == MD_MULHSU);
        b_signed = (op_i == MD_MULH);
    end

    assign a_ext   = {a_signed & operand_a_i[`XLEN-1], operand_a_i};
    assign b_ext   = {b_signed & operand_b_i[`XLEN-1], operand_b_i};
    assign product = a_ext * b_ext; // low 2*XLEN bits are exact

    assign div_zero = (operand_b_i == '0);
    assign div_ovf  = (operand_a_i == MOST_NEG) && (operand_b_i == '1);

    // dividing by one in the overflow case already yields dividend and zero remainder
    assign sdivisor = (div_zero || div_ovf) ? ONE : operand_b_i;
    assign udivisor = div_zero ? ONE : operand_b_i;

    assign quot_s = $unsigned($signed(operand_a_i) / $signed(sdivisor));
    assign rem_s  = $unsigned($signed(operand_a_i) % $signed(sdivisor)); // sign of dividend
    assign quot_u = operand_a_i / udivisor;
    assign rem_u  = operand_a_i % udivisor;

    always_comb begin
        case (op_i)
            MD_MUL:    result_o = product[`XLEN-1:0];
            MD_MULH:   result_o = product[2*`XLEN-1:`XLEN];
            MD_MULHSU: result_o = product[2*`XLEN-1:`XLEN];
            MD_MULHU:  result_o = product[2*`XLEN-1:`XLEN];
            MD_DIV:    result_o = div_zero ? '1 : quot_s;
            MD_DIVU:   result_o = div_zero ? '1 : quot_u;
            MD_REM:    result_o = div_zero ? operand_a_i : rem_s;
            MD_REMU:   result_o = div_zero ? operand_a_i : rem_u;
            default:   result_o = '0;
        endcase
    end

endmodule

//--- verilog/branch_resolver.sv
// pc update decision for jumps and conditional branches
`timescale 1ns/10ps

module branch_resolver
    import exec_uop_pkg::*;
    import exec_data_pkg::*;
(
    input  instr_kind_e  kind_i,
    input  branch_cond_e cond_i,
    input  cmp_flags_t   flags_i,
    output logic         update_o
);

    logic cond_holds;

    always_comb begin
        case (cond_i)
            BR_EQ:   cond_holds =  flags_i.eq;
            BR_NE:   cond_holds = !flags_i.eq;
            BR_LT:   cond_holds =  flags_i.lt;
            BR_GE:   cond_holds = !flags_i.lt;
            BR_LTU:  cond_holds =  flags_i.ltu;
            BR_GEU:  cond_holds = !flags_i.ltu;
            default: cond_holds = 1'b0; // unused codes never take a branch
        endcase
    end

    always_comb begin
        case (kind_i)
            KIND_JUMP: begin
                update_o = 1'b1; // unconditional
            end
            KIND_BRANCH: begin
                update_o = cond_holds;
            end
            default: begin
                update_o = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/execute_stage.sv
// execute stage with alu, mul/div unit, branch resolution and writeback register
`timescale 1ns/10ps

`include "exec_settings.svh"

module execute_stage
    import exec_uop_pkg::*;
    import exec_data_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  uop_t                   uop_i,
    input  logic [`XLEN-1:0]       operand_a_i, // already picked from reg, imm or pc
    input  logic [`XLEN-1:0]       operand_b_i,
    input  cmp_flags_t             flags_i,     // from the raw register values

    input  logic                   write_en_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`XLEN-1:0]       pc_plus4_i,

    output redirect_t              redirect_o,  // same cycle to fetch
    output writeback_t             writeback_o  // one cycle later
);

    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] muldiv_result;
    logic [`XLEN-1:0] rd_value;
    logic             update;
    writeback_t       wb_next;

    alu i_alu (
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (uop_i.alu_op),
        .result_o    (alu_result)
    );

    muldiv_unit i_muldiv_unit (
        .op_i        (uop_i.muldiv_op),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (muldiv_result)
    );

    branch_resolver i_branch_resolver (
        .kind_i   (uop_i.kind),
        .cond_i   (uop_i.branch_cond),
        .flags_i  (flags_i),
        .update_o (update)
    );

    // operands are chosen upstream so the alu sum is the target address
    assign redirect_o.target = alu_result;
    assign redirect_o.update = update;

    always_comb begin
        case (uop_i.unit)
            UNIT_MULDIV: rd_value = muldiv_result;
            default:     rd_value = alu_result;
        endcase
    end

    assign wb_next.write_en = write_en_i;
    assign wb_next.rd_addr  = rd_addr_i;
    assign wb_next.rd_value = rd_value;
    assign wb_next.pc_plus4 = pc_plus4_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            writeback_o <= '0; // write_en low out of reset
        end else begin
            writeback_o <= wb_next;
        end
    end

endmodule

//--- tb/execute_stage_sva.sv
// bound checks on execute stage reset state, redirect and writeback timing
`timescale 1ns/10ps

`include "exec_settings.svh"

module execute_stage_sva
    import exec_uop_pkg::*;
    import exec_data_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_i,
    input uop_t                   uop_i,
    input logic                   write_en_i,
    input logic [`REG_ADDR_W-1:0] rd_addr_i,
    input redirect_t              redirect_i,
    input writeback_t             writeback_i
);

    reset_clears_wb: assert property (@(posedge clk_i) rst_i |=> (writeback_i == '0))
        else $error("writeback bundle not cleared after reset");

    // plain ops never move the pc
    other_no_update: assert property (@(posedge clk_i)
        (uop_i.kind == KIND_OTHER) |-> !redirect_i.update)
        else $error("redirect update raised for a non-control op");

    wb_follows_inputs: assert property (@(posedge clk_i)
        !rst_i |=> (writeback_i.rd_addr == $past(rd_addr_i))
                   && (writeback_i.write_en == $past(write_en_i)))
        else $error("writeback address or enable does not follow the previous inputs");

endmodule

bind execute_stage execute_stage_sva i_execute_stage_sva (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .uop_i       (uop_i),
    .write_en_i  (write_en_i),
    .rd_addr_i   (rd_addr_i),
    .redirect_i  (redirect_o),
    .writeback_i (writeback_o)
);

//--- tb/tb_execute_stage.sv
// testbench for the execute stage with a reference model and directed tests
`timescale 1ns/10ps

`include "exec_settings.svh"

module tb_execute_stage
    import exec_uop_pkg::*;
    import exec_data_pkg::*;
();

    localparam logic [31:0]        SEED           = 32'hec9b;
    localparam logic [`XLEN-1:0]   MOST_NEG       = {1'b1, {(`XLEN-1){1'b0}}};
    localparam int                 ALU_CORNERS    = 6;
    localparam int                 ALU_RANDOM     = 50;
    localparam int                 MULDIV_RANDOM  = 20;
    localparam int                 JUMP_COUNT     = 8;
    localparam int                 STREAM_LEN     = 32;
    localparam int                 TEST_CYCLES    = 16 + 10 * (ALU_CORNERS * ALU_CORNERS + ALU_RANDOM)
                                                    + 8 * (MULDIV_RANDOM + 2) + 6 * 8
                                                    + JUMP_COUNT + STREAM_LEN + 8;
    localparam int                 TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                   clk;
    logic                   rst;
    uop_t                   uop;
    logic [`XLEN-1:0]       operand_a;
    logic [`XLEN-1:0]       operand_b;
    cmp_flags_t             flags;
    logic                   write_en;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       pc_plus4;
    redirect_t              redirect;
    writeback_t             writeback;

    int               wb_errors;
    int               redirect_errors;
    int               cycle_count = 0;
    logic             pending_valid; // an issued op still owes its writeback
    writeback_t       pending_wb;

    execute_stage i_execute_stage (
        .clk_i       (clk),
        .rst_i       (rst),
        .uop_i       (uop),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .flags_i     (flags),
        .write_en_i  (write_en),
        .rd_addr_i   (rd_addr),
        .pc_plus4_i  (pc_plus4),
        .redirect_o  (redirect),
        .writeback_o (writeback)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [`XLEN-1:0] rand_word();
        return $urandom;
    endfunction

    function automatic logic [`XLEN-1:0] corner_value(input int idx);
        case (idx)
            0:       return '0;
            1:       return {{(`XLEN-1){1'b0}}, 1'b1};
            2:       return '1;
            3:       return MOST_NEG;
            4:       return ~MOST_NEG;
            default: return `XLEN'h1f; // largest shift amount
        endcase
    endfunction

    function automatic uop_t make_uop(input exec_unit_e unit, input alu_op_e aop,
                                      input muldiv_op_e mop, input branch_cond_e cond,
                                      input instr_kind_e kind);
        uop_t u;
        u.unit        = unit;
        u.alu_op      = aop;
        u.muldiv_op   = mop;
        u.branch_cond = cond;
        u.kind        = kind;
        return u;
    endfunction

    function automatic logic [`XLEN-1:0] model_alu(input alu_op_e op, input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0]; // only the low five bits count
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (~({`XLEN{1'b1}} >> sh) & {`XLEN{a[`XLEN-1]}});
            ALU_SLT:  return {{(`XLEN-1){1'b0}}, (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : a < b};
            ALU_SLTU: return {{(`XLEN-1){1'b0}}, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] model_muldiv(input muldiv_op_e op,
                                                      input logic [`XLEN-1:0] a,
                                                      input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0]      prod_ss;
        logic [2*`XLEN-1:0]      prod_su;
        logic [2*`XLEN-1:0]      prod_uu;
        logic signed [`XLEN-1:0] sa;
        logic signed [`XLEN-1:0] sb;
        logic                    zero_div;
        logic                    overflow;
        // sign or zero extend to 64 bits so the low 64 bits of each product are exact
        prod_ss  = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
        prod_su  = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{1'b0}}, b};
        prod_uu  = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        sa       = a;
        sb       = b;
        zero_div = (b == '0);
        overflow = (a == MOST_NEG) && (b == '1);
        case (op)
            MD_MUL:    return prod_uu[`XLEN-1:0];
            MD_MULH:   return prod_ss[2*`XLEN-1:`XLEN];
            MD_MULHSU: return prod_su[2*`XLEN-1:`XLEN];
            MD_MULHU:  return prod_uu[2*`XLEN-1:`XLEN];
            MD_DIV:    return zero_div ? '1 : (overflow ? a : $unsigned(sa / sb));
            MD_DIVU:   return zero_div ? '1 : a / b;
            MD_REM:    return zero_div ? a : (overflow ? '0 : $unsigned(sa % sb));
            default:   return zero_div ? a : a % b; // remu
        endcase
    endfunction

    function automatic logic model_update(input instr_kind_e kind, input branch_cond_e cond,
                                          input cmp_flags_t f);
        logic taken;
        case (cond)
            BR_EQ:   taken = f.eq;
            BR_NE:   taken = ~f.eq;
            BR_LT:   taken = f.lt;
            BR_GE:   taken = ~f.lt;
            BR_LTU:  taken = f.ltu;
            BR_GEU:  taken = ~f.ltu;
            default: taken = 1'b0;
        endcase
        return (kind == KIND_JUMP) || ((kind == KIND_BRANCH) && taken);
    endfunction

    task automatic check_writeback(input writeback_t actual, input writeback_t expected);
        if (actual.write_en !== expected.write_en) begin
            $display("Mismatch writeback_o.write_en: expected %h, got %h at %0t",
                     expected.write_en, actual.write_en, $time);
            wb_errors++;
        end
        if (actual.rd_addr !== expected.rd_addr) begin
            $display("Mismatch writeback_o.rd_addr: expected %h, got %h at %0t",
                     expected.rd_addr, actual.rd_addr, $time);
            wb_errors++;
        end
        if (actual.rd_value !== expected.rd_value) begin
            $display("Mismatch writeback_o.rd_value: expected %h, got %h at %0t",
                     expected.rd_value, actual.rd_value, $time);
            wb_errors++;
        end
        if (actual.pc_plus4 !== expected.pc_plus4) begin
            $display("Mismatch writeback_o.pc_plus4: expected %h, got %h at %0t",
                     expected.pc_plus4, actual.pc_plus4, $time);
            wb_errors++;
        end
    endtask

    task automatic check_redirect(input redirect_t actual, input redirect_t expected);
        if (actual.target !== expected.target) begin
            $display("Mismatch redirect_o.target: expected %h, got %h at %0t",
                     expected.target, actual.target, $time);
            redirect_errors++;
        end
        if (actual.update !== expected.update) begin
            $display("Mismatch redirect_o.update: expected %h, got %h at %0t",
                     expected.update, actual.update, $time);
            redirect_errors++;
        end
    endtask

    // one op per cycle, redirect checked mid-cycle, writeback one cycle later
    task automatic issue_op(input uop_t u, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                            input cmp_flags_t f, input logic we,
                            input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] pc);
        redirect_t  exp_redirect;
        writeback_t exp_wb;
        @(posedge clk);
        uop       <= u;
        operand_a <= a;
        operand_b <= b;
        flags     <= f;
        write_en  <= we;
        rd_addr   <= rd;
        pc_plus4  <= pc;
        @(negedge clk);
        if (pending_valid) begin
            check_writeback(writeback, pending_wb);
        end
        exp_redirect.target = model_alu(u.alu_op, a, b);
        exp_redirect.update = model_update(u.kind, u.branch_cond, f);
        check_redirect(redirect, exp_redirect);
        exp_wb.write_en = we;
        exp_wb.rd_addr  = rd;
        exp_wb.rd_value = (u.unit == UNIT_MULDIV) ? model_muldiv(u.muldiv_op, a, b)
                                                  : model_alu(u.alu_op, a, b);
        exp_wb.pc_plus4 = pc;
        pending_wb      = exp_wb;
        pending_valid   = 1'b1;
    endtask

    task automatic issue_random_ctrl(input uop_t u, input logic [`XLEN-1:0] a,
                                     input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] r;
        r = rand_word();
        issue_op(u, a, b, r[2:0], r[3], r[`REG_ADDR_W+3:4], rand_word());
    endtask

    task automatic drain_writeback();
        @(posedge clk);
        uop      <= make_uop(UNIT_ALU, ALU_ADD, MD_MUL, BR_EQ, KIND_OTHER);
        write_en <= 1'b0;
        @(negedge clk);
        if (pending_valid) begin
            check_writeback(writeback, pending_wb);
        end
        pending_valid = 1'b0;
    endtask

    task automatic test_reset();
        writeback_t       zero_wb;
        redirect_t        exp_redirect;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] r;
        logic [`XLEN-1:0] pc;
        zero_wb = '0;
        repeat (15) begin
            a  = rand_word();
            b  = rand_word();
            r  = rand_word();
            pc = rand_word();
            @(posedge clk);
            operand_a <= a;
            operand_b <= b;
            flags     <= r[2:0];
            write_en  <= r[3];
            rd_addr   <= r[`REG_ADDR_W+3:4];
            pc_plus4  <= pc;
            @(negedge clk);
            exp_redirect.target = a + b; // idle uop is an add
            exp_redirect.update = 1'b0;
            check_redirect(redirect, exp_redirect);
            check_writeback(writeback, zero_wb);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_writeback(writeback, zero_wb);
        pending_valid = 1'b0;
    endtask

    task automatic test_alu();
        uop_t u;
        for (int op = 0; op < 10; op++) begin
            u = make_uop(UNIT_ALU, alu_op_e'(op[3:0]), MD_MUL, BR_EQ, KIND_OTHER);
            for (int i = 0; i < ALU_CORNERS; i++) begin
                for (int j = 0; j < ALU_CORNERS; j++) begin
                    issue_random_ctrl(u, corner_value(i), corner_value(j));
                end
            end
            repeat (ALU_RANDOM) issue_random_ctrl(u, rand_word(), rand_word());
        end
        drain_writeback();
    endtask

    task automatic test_muldiv();
        uop_t             u;
        logic [`XLEN-1:0] r;
        for (int op = 0; op < 8; op++) begin
            u = make_uop(UNIT_MULDIV, ALU_ADD, muldiv_op_e'(op[2:0]), BR_EQ, KIND_OTHER);
            for (int i = 0; i < MULDIV_RANDOM; i++) begin
                r = rand_word();
                // every other divisor is a small signed value
                issue_random_ctrl(u, rand_word(),
                                  (i % 2 == 0) ? r : {{(`XLEN-8){r[`XLEN-1]}}, r[7:0]});
            end
            issue_random_ctrl(u, rand_word(), '0);
            issue_random_ctrl(u, MOST_NEG, '1);
        end
        drain_writeback();
    endtask

    task automatic test_branches();
        uop_t       u;
        cmp_flags_t f;
        for (int c = 0; c < 6; c++) begin
            u = make_uop(UNIT_ALU, ALU_ADD, MD_MUL, branch_cond_e'(c[2:0]), KIND_BRANCH);
            for (int fb = 0; fb < 8; fb++) begin
                f = fb[2:0];
                issue_op(u, rand_word(), rand_word(), f, 1'b0, '0, rand_word());
            end
        end
        drain_writeback();
    endtask

    task automatic test_jumps_and_stream();
        uop_t             u;
        logic [`XLEN-1:0] r;
        logic [`XLEN-1:0] idx;
        repeat (JUMP_COUNT) begin
            r   = rand_word();
            idx = r % 6;
            u   = make_uop(UNIT_ALU, ALU_ADD, MD_MUL, branch_cond_e'(idx[2:0]), KIND_JUMP);
            issue_op(u, rand_word(), rand_word(), r[2:0], 1'b1, r[12:8], rand_word());
        end
        for (int i = 0; i < STREAM_LEN; i++) begin
            r = rand_word();
            if (i % 2 == 0) begin
                idx = r % 10;
                u   = make_uop(UNIT_ALU, alu_op_e'(idx[3:0]), MD_MUL, BR_LT,
                               r[20] ? KIND_BRANCH : KIND_OTHER);
            end else begin
                u = make_uop(UNIT_MULDIV, ALU_ADD, muldiv_op_e'(r[2:0]), BR_EQ, KIND_OTHER);
            end
            issue_random_ctrl(u, rand_word(), rand_word());
        end
        drain_writeback();
    endtask

    initial begin
        wb_errors       = 0;
        redirect_errors = 0;
        pending_valid   = 1'b0;
        void'($urandom(SEED));
        rst       <= 1'b1;
        uop       <= make_uop(UNIT_ALU, ALU_ADD, MD_MUL, BR_EQ, KIND_OTHER);
        operand_a <= '0;
        operand_b <= '0;
        flags     <= '0;
        write_en  <= 1'b0;
        rd_addr   <= '0;
        pc_plus4  <= '0;
        test_reset();
        test_alu();
        test_muldiv();
        test_branches();
        test_jumps_and_stream();
        $display("error count: %0d writeback, %0d redirect", wb_errors, redirect_errors);
        if (wb_errors + redirect_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- execute_stage.f
+incdir+verilog
verilog/exec_uop_pkg.sv
verilog/exec_data_pkg.sv
verilog/alu.sv
verilog/muldiv_unit.sv
verilog/branch_resolver.sv
verilog/execute_stage.sv
tb/execute_stage_sva.sv
tb/tb_execute_stage.sv

//--- Makefile
# Verilator flow for the execute stage testbench

TOP := tb_execute_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f execute_stage.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f execute_stage.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
